// ==== all.f ====
design/adpcm_pkg.sv
design/adpcm_channel.sv
design/adpcm_fetch_arbiter.sv
design/sample_load_ctrl.sv
design/adpcm_fetch_top.sv
sim/tb_clock_gen.sv
sim/adpcm_fetch_props.sv
sim/tb_adpcm_fetch.sv

// ==== design/adpcm_channel.sv ====
// ================================================
// One sound chip sample channel
// Read enable falling edge detection
// Pending request flag and returned byte register
// ================================================
`timescale 1ns/100ps
`default_nettype none

module adpcm_channel
(
	input  wire        clk_sys,
	input  wire        nBNKB,
	// Active-low ROM read enable from the sound chip
	input  wire        roe_n,
	// Arbiter takes the pending request
	input  wire        grant,
	// Read for this channel has finished
	input  wire        done,
	input  wire  [7:0] done_byte,
	output logic       pending,
	output logic [7:0] data
);

	// Read enable history, newest sample in bit 0
	logic [1:0] roe_sr;
	// High for one cycle after roe_n has gone low
	logic       roe_fall;

	// Old sample high and new sample low
	assign roe_fall = roe_sr[1] & ~roe_sr[0];

	// ================================================
	// Edge detect and request flag
	// ================================================

	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			// Idle level of roe_n, no edge out of reset
			roe_sr  <= 2'b11;
			pending <= 1'b0;
		end
		else
		begin
			roe_sr <= {roe_sr[0], roe_n};

			// Set on a new edge, clear when granted
			// An edge while still pending merges into the same read
			// An edge in the grant cycle starts a fresh request
			pending <= roe_fall | (pending & ~grant);
		end
	end

	// ================================================
	// Sample byte
	// ================================================

	// Holds the last fetched byte until the next read ends
	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
			data <= 8'h00;
		else if (done)
			data <= done_byte;
	end

endmodule

`default_nettype wire

// ==== design/adpcm_fetch_arbiter.sv ====
// ================================================
// Sample read arbiter for channels A and B
// Priority grant with one read in flight
// Fetch address latch and read request toggle
// Ack register and byte select on completion
// ================================================
`timescale 1ns/100ps
`default_nettype none

module adpcm_fetch_arbiter
(
	input  wire                           clk_sys,
	input  wire                           nBNKB,
	input  wire                           a_pending,
	input  wire                           b_pending,
	input  wire [adpcm_pkg::A_ADDR_W-1:0] a_addr,
	input  wire [adpcm_pkg::A_BANK_W-1:0] a_bank,
	input  wire [adpcm_pkg::B_ADDR_W-1:0] b_addr,
	// Selects the lower or upper half for channel B
	input  wire                           use_pcm,
	input  wire adpcm_pkg::mem_rsp_t      rsp,
	output logic                          a_grant,
	output logic                          b_grant,
	output logic                          a_done,
	output logic                          b_done,
	output logic [7:0]                    done_byte,
	output adpcm_pkg::mem_rd_cmd_t        rd
);
	import adpcm_pkg::*;

	chan_sel_e   owner;
	fetch_addr_u fetch_addr;
	logic        rd_req;
	logic        rd_ack_q;
	logic [15:0] rd_data_q;
	logic        idle;
	logic        rd_match;

	// ================================================
	// Grant and completion
	// ================================================

	assign idle = (owner == CHAN_NONE);

	// B first, it may run faster than A
	assign b_grant = idle & b_pending;
	assign a_grant = idle & a_pending & ~b_pending;

	// Read is over once the registered ack catches up
	assign rd_match = (rd_ack_q == rd_req);
	assign a_done   = (owner == CHAN_A) & rd_match;
	assign b_done   = (owner == CHAN_B) & rd_match;

	// Low address bit picks the byte within the word
	assign done_byte = fetch_addr[0] ? rd_data_q[15:8] : rd_data_q[7:0];

	// Word address drops the byte select bit
	assign rd = '{req: rd_req, addr: fetch_addr[SAMPLE_ADDR_W-1:1]};

	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			owner    <= CHAN_NONE;
			rd_req   <= 1'b0;
			rd_ack_q <= 1'b0;
		end
		else
		begin
			rd_ack_q <= rsp.rd_ack;

			if (b_grant)
			begin
				owner  <= CHAN_B;
				rd_req <= ~rd_req;
			end
			else if (a_grant)
			begin
				owner  <= CHAN_A;
				rd_req <= ~rd_req;
			end
			else if (a_done | b_done)
				owner <= CHAN_NONE;
		end
	end

	// ================================================
	// Address latch and read data
	// ================================================

	always_ff @(posedge clk_sys)
	begin
		// Sampled together with the ack
		rd_data_q <= rsp.rd_data;

		// Address held stable for the whole read
		if (b_grant)
			fetch_addr.b_view <= '{region: ~use_pcm, addr: b_addr};
		else if (a_grant)
			fetch_addr.a_view <= '{pad: 1'b0, bank: a_bank, addr: a_addr};
	end

endmodule

`default_nettype wire

// ==== design/adpcm_fetch_top.sv ====
// ================================================
// ADPCM sample memory path top level
// Two channels, the read arbiter and the loader
// ================================================
`timescale 1ns/100ps
`default_nettype none

module adpcm_fetch_top
(
	input  wire                           clk_sys,
	input  wire                           nBNKB,
	// Downloader
	input  wire adpcm_pkg::ioctl_t        ioctl,
	output logic                          ioctl_wait,
	// External memory
	output adpcm_pkg::mem_wr_cmd_t        mem_wr,
	output adpcm_pkg::mem_rd_cmd_t        mem_rd,
	input  wire adpcm_pkg::mem_rsp_t      mem_rsp,
	// Sound chip
	input  wire                           a_roe_n,
	input  wire [adpcm_pkg::A_ADDR_W-1:0] a_addr,
	input  wire [adpcm_pkg::A_BANK_W-1:0] a_bank,
	input  wire                           b_roe_n,
	input  wire [adpcm_pkg::B_ADDR_W-1:0] b_addr,
	input  wire                           use_pcm,
	output logic [7:0]                    a_data,
	output logic [7:0]                    b_data
);

	logic       a_pending;
	logic       b_pending;
	logic       a_grant;
	logic       b_grant;
	logic       a_done;
	logic       b_done;
	// Shared by both channels, only the owner loads it
	logic [7:0] done_byte;

	// Channel A
	adpcm_channel u_chan_a (
		.clk_sys(clk_sys), .nBNKB(nBNKB),
		.roe_n(a_roe_n),
		.grant(a_grant), .done(a_done), .done_byte(done_byte),
		.pending(a_pending), .data(a_data)
	);

	// Channel B
	adpcm_channel u_chan_b (
		.clk_sys(clk_sys), .nBNKB(nBNKB),
		.roe_n(b_roe_n),
		.grant(b_grant), .done(b_done), .done_byte(done_byte),
		.pending(b_pending), .data(b_data)
	);

	adpcm_fetch_arbiter u_arbiter (
		.clk_sys(clk_sys), .nBNKB(nBNKB),
		.a_pending(a_pending), .b_pending(b_pending),
		.a_addr(a_addr), .a_bank(a_bank), .b_addr(b_addr),
		.use_pcm(use_pcm),
		.rsp(mem_rsp),
		.a_grant(a_grant), .b_grant(b_grant),
		.a_done(a_done), .b_done(b_done),
		.done_byte(done_byte),
		.rd(mem_rd)
	);

	// Write side only needs the write ack
	sample_load_ctrl u_loader (
		.clk_sys(clk_sys), .nBNKB(nBNKB),
		.ioctl(ioctl),
		.wr_ack(mem_rsp.wr_ack),
		.wr(mem_wr),
		.ioctl_wait(ioctl_wait)
	);

endmodule

`default_nettype wire

// ==== design/adpcm_pkg.sv ====
// ================================================
// Shared definitions of the ADPCM sample memory path
// Sample memory geometry and download index range
// Download bundle, memory commands and response
// Fetch address union and read owner encoding
// ================================================
`default_nettype none

package adpcm_pkg;

	// ================================================
	// Sample memory geometry
	// ================================================

	// Byte address into 32 MB of sample memory
	localparam int SAMPLE_ADDR_W = 25;
	// Memory is 16 bits wide
	localparam int WORD_ADDR_W = 24;

	// Sound chip address widths
	localparam int A_ADDR_W = 20;
	localparam int A_BANK_W = 4;
	localparam int B_ADDR_W = 24;

	// Sample ROMs occupy download indices 16 to 63
	localparam logic [7:0] INDEX_VROM_FIRST = 8'd16;
	localparam logic [7:0] INDEX_VROM_END = 8'd64;
	// Each index owns one 512 KB slot
	localparam int VROM_SLOT_SHIFT = 19;

	// ================================================
	// Bundles
	// ================================================

	// Downloader side, addr is a byte address
	typedef struct packed {
		logic                     download;
		logic                     wr;
		logic [SAMPLE_ADDR_W-1:0] addr;
		logic [7:0]               index;
		logic [15:0]              data;
	} ioctl_t;

	// Write toward memory, req is a toggle
	typedef struct packed {
		logic                   req;
		logic [WORD_ADDR_W-1:0] addr;
		logic [15:0]            data;
	} mem_wr_cmd_t;

	// Read toward memory, req is a toggle
	typedef struct packed {
		logic                   req;
		logic [WORD_ADDR_W-1:0] addr;
	} mem_rd_cmd_t;

	// Ack toggles follow the request toggles
	typedef struct packed {
		logic        wr_ack;
		logic        rd_ack;
		logic [15:0] rd_data;
	} mem_rsp_t;

	// Channel A form
	typedef struct packed {
		logic                pad;
		logic [A_BANK_W-1:0] bank;
		logic [A_ADDR_W-1:0] addr;
	} fetch_a_t;

	// Channel B form, region picks the upper 16 MB
	typedef struct packed {
		logic                region;
		logic [B_ADDR_W-1:0] addr;
	} fetch_b_t;

	// Latched 25-bit byte address seen by either channel
	typedef union packed {
		fetch_a_t a_view;
		fetch_b_t b_view;
	} fetch_addr_u;

	// Owner of the read in flight
	typedef enum logic [1:0] {
		CHAN_NONE,
		CHAN_A,
		CHAN_B
	} chan_sel_e;

endpackage

`default_nettype wire

// ==== design/sample_load_ctrl.sv ====
// ================================================
// Sample ROM download to external memory
// Index range filter and slot address computation
// Write request toggle and downloader wait
// ================================================
`timescale 1ns/100ps
`default_nettype none

module sample_load_ctrl
(
	input  wire                     clk_sys,
	input  wire                     nBNKB,
	input  wire adpcm_pkg::ioctl_t  ioctl,
	// Write ack toggle from memory
	input  wire                     wr_ack,
	output adpcm_pkg::mem_wr_cmd_t  wr,
	output logic                    ioctl_wait
);
	import adpcm_pkg::*;

	logic                     in_range;
	logic                     pcm_loading;
	logic                     accept;
	logic                     dl_q;
	logic                     wr_req;
	logic                     wr_ack_q;
	logic [7:0]               slot_idx;
	logic [SAMPLE_ADDR_W-1:0] slot_base;
	logic [SAMPLE_ADDR_W-1:0] load_addr;
	logic [WORD_ADDR_W-1:0]   wr_addr;
	logic [15:0]              wr_data;

	// Only sample ROM indices go to this memory
	assign in_range    = (ioctl.index >= INDEX_VROM_FIRST) && (ioctl.index < INDEX_VROM_END);
	assign pcm_loading = ioctl.download & in_range;
	assign accept      = pcm_loading & ioctl.wr;

	// Each index starts a new 512 KB slot
	assign slot_idx  = ioctl.index - INDEX_VROM_FIRST;
	assign slot_base = SAMPLE_ADDR_W'(slot_idx) << VROM_SLOT_SHIFT;
	assign load_addr = ioctl.addr + slot_base;

	assign wr = '{req: wr_req, addr: wr_addr, data: wr_data};

	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			dl_q       <= 1'b0;
			wr_req     <= 1'b0;
			wr_ack_q   <= 1'b0;
			ioctl_wait <= 1'b0;
		end
		else
		begin
			dl_q     <= pcm_loading;
			wr_ack_q <= wr_ack;

			// End of the sample download releases the downloader
			if (dl_q & ~pcm_loading)
				ioctl_wait <= 1'b0;
			else if (accept)
			begin
				// Toggle continues across downloads
				wr_req     <= ~wr_req;
				ioctl_wait <= 1'b1;
			end
			else if (ioctl_wait && (wr_ack_q == wr_req))
				ioctl_wait <= 1'b0;
		end
	end

	// Word address and data held until the next accepted write
	always_ff @(posedge clk_sys)
	begin
		if (accept)
		begin
			wr_addr <= load_addr[SAMPLE_ADDR_W-1:1];
			wr_data <= ioctl.data;
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the ADPCM fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_adpcm_fetch

verilator --binary --timing --assert -f all.f --top-module "$TOP" \
	-Mdir "$BUILD_DIR" -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
exit 0

// ==== sim/adpcm_fetch_props.sv ====
// ================================================
// Handshake checks bound into arbiter and loader
// Request hold, done pulse width and wait out of reset
// ================================================
`timescale 1ns/100ps
`default_nettype none

module adpcm_fetch_props
(
	input wire clk_sys,
	input wire nBNKB,
	// Request toggle and its registered ack
	input wire req,
	input wire ack_q,
	input wire a_done,
	input wire b_done,
	// Downloader wait is tied low in the arbiter
	input wire stall
);

	// No new request until the ack has caught up
	req_hold: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		(req != ack_q) |=> $stable(req))
		else $error("request toggled while an access was outstanding");

	a_done_pulse: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		a_done |=> !a_done)
		else $error("channel A done lasted more than one cycle");

	b_done_pulse: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		b_done |=> !b_done)
		else $error("channel B done lasted more than one cycle");

	// Downloader is not stalled on the first edge after reset
	reset_exit: assert property (@(posedge clk_sys) $rose(nBNKB) |-> !stall)
		else $error("wait high on leaving reset");

endmodule

// Read side
bind adpcm_fetch_arbiter adpcm_fetch_props u_props (
	.clk_sys(clk_sys), .nBNKB(nBNKB), .req(rd_req), .ack_q(rd_ack_q),
	.a_done(a_done), .b_done(b_done), .stall(1'b0)
);

// Write side
bind sample_load_ctrl adpcm_fetch_props u_props (
	.clk_sys(clk_sys), .nBNKB(nBNKB), .req(wr_req), .ack_q(wr_ack_q),
	.a_done(1'b0), .b_done(1'b0), .stall(ioctl_wait)
);

`default_nettype wire

// ==== sim/tb_adpcm_fetch.sv ====
// ================================================
// Testbench for the ADPCM sample memory path
// Toggle handshake memory model with random latency
// Downloads, fetches and reference byte checks
// ================================================
`timescale 1ns/100ps
`default_nettype none

module tb_adpcm_fetch;
	import adpcm_pkg::*;

	// One expected read in service order
	typedef struct packed {
		logic                     chan_b;
		logic [SAMPLE_ADDR_W-1:0] byte_addr;
	} fetch_exp_t;

	// Read seen by the memory model with the cycle of its ack
	typedef struct packed {
		logic [WORD_ADDR_W-1:0] addr;
		logic [31:0]            cycle;
	} read_ack_t;

	logic                clk_sys;
	logic                nBNKB;
	ioctl_t              ioctl;
	logic                ioctl_wait;
	mem_wr_cmd_t         mem_wr;
	mem_rd_cmd_t         mem_rd;
	mem_rsp_t            mem_rsp;
	logic                a_roe_n;
	logic [A_ADDR_W-1:0] a_addr;
	logic [A_BANK_W-1:0] a_bank;
	logic                b_roe_n;
	logic [B_ADDR_W-1:0] b_addr;
	logic                use_pcm;
	logic [7:0]          a_data;
	logic [7:0]          b_data;

	// Memory model state
	logic        wr_ack_r;
	logic        rd_ack_r;
	logic [15:0] rd_data_r;
	logic [15:0] wmem [logic [WORD_ADDR_W-1:0]];
	fetch_exp_t  exp_q[$];
	read_ack_t   ack_q[$];
	int          cycle = 0;
	int          wr_count = 0;
	int          errors = 0;
	int          timeouts = 0;

	assign mem_rsp = '{wr_ack: wr_ack_r, rd_ack: rd_ack_r, rd_data: rd_data_r};

	tb_clock_gen u_clk (.clk_sys(clk_sys), .nBNKB(nBNKB));

	adpcm_fetch_top dut0 (
		.clk_sys(clk_sys), .nBNKB(nBNKB),
		.ioctl(ioctl), .ioctl_wait(ioctl_wait),
		.mem_wr(mem_wr), .mem_rd(mem_rd), .mem_rsp(mem_rsp),
		.a_roe_n(a_roe_n), .a_addr(a_addr), .a_bank(a_bank),
		.b_roe_n(b_roe_n), .b_addr(b_addr), .use_pcm(use_pcm),
		.a_data(a_data), .b_data(b_data)
	);

	always @(posedge clk_sys)
		cycle <= cycle + 1;

	// ================================================
	// Helpers and reference model
	// ================================================

	// Inputs change and outputs are sampled 1 ns after the edge
	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic flag_error(input string msg);
		errors++;
		$display("Error at %0d ns: %s", $time, msg);
	endtask

	// Unwritten words read back a pattern of the whole word address
	function automatic logic [15:0] fill_word(input logic [WORD_ADDR_W-1:0] addr);
		return addr[15:0] ^ {addr[7:0], addr[23:16]} ^ 16'hc3a5;
	endfunction

	function automatic logic [15:0] stored_word(input logic [WORD_ADDR_W-1:0] addr);
		if (wmem.exists(addr))
			return wmem[addr];
		return fill_word(addr);
	endfunction

	// Bit 0 of the byte address picks the high byte
	function automatic logic [7:0] expected_byte(input logic [SAMPLE_ADDR_W-1:0] byte_addr);
		logic [15:0] word;
		word = stored_word(byte_addr[24:1]);
		return byte_addr[0] ? word[15:8] : word[7:0];
	endfunction

	// Each index from 16 owns a 512 KB slot
	function automatic logic [WORD_ADDR_W-1:0] load_word_addr(input logic [7:0] index,
		input logic [SAMPLE_ADDR_W-1:0] byte_addr);
		logic [SAMPLE_ADDR_W-1:0] full;
		full = byte_addr + ({17'd0, index - 8'd16} << 19);
		return full[24:1];
	endfunction

	// Half the targets fall inside the downloaded windows
	function automatic logic [SAMPLE_ADDR_W-1:0] pick_target();
		logic [SAMPLE_ADDR_W-1:0] base;
		if ($urandom % 2 == 0)
			return 25'($urandom);
		case ($urandom % 4)
			0:       base = 25'h0000000;
			1:       base = 25'h0080000;
			2:       base = 25'h0c00100;
			default: base = 25'h1000000;
		endcase
		return base + 25'($urandom % 32);
	endfunction

	// ================================================
	// Memory model with one process per side
	// ================================================

	initial
	begin : write_model
		int lat;
		wr_ack_r = 1'b0;
		forever
		begin
			tick();
			if (mem_wr.req != wr_ack_r)
			begin
				lat = 2 + int'($urandom % 8);
				repeat (lat) tick();
				wmem[mem_wr.addr] = mem_wr.data;
				wr_count++;
				wr_ack_r = mem_wr.req;
			end
		end
	end

	initial
	begin : read_model
		int lat;
		rd_ack_r  = 1'b0;
		rd_data_r = 16'h0000;
		forever
		begin
			tick();
			if (mem_rd.req != rd_ack_r)
			begin
				lat = 2 + int'($urandom % 8);
				repeat (lat) tick();
				rd_data_r = stored_word(mem_rd.addr);
				ack_q.push_back(read_ack_t'{addr: mem_rd.addr, cycle: 32'(cycle)});
				rd_ack_r = mem_rd.req;
			end
		end
	end

	// Channel data is due two cycles after the read ack
	initial
	begin : compare_reads
		read_ack_t  ack_e;
		fetch_exp_t exp_e;
		logic [7:0] got;
		forever
		begin
			tick();
			if (ack_q.size() > 0)
			begin
				ack_e = ack_q[0];
				if (cycle == int'(ack_e.cycle) + 2)
				begin
					ack_e = ack_q.pop_front();
					assert (exp_q.size() > 0)
					else flag_error("memory read issued with no fetch outstanding");
					if (exp_q.size() > 0)
					begin
						exp_e = exp_q.pop_front();
						got   = exp_e.chan_b ? b_data : a_data;
						assert (ack_e.addr == exp_e.byte_addr[24:1])
						else flag_error($sformatf("read of word %h, expected %h (chan_b=%b)",
							ack_e.addr, exp_e.byte_addr[24:1], exp_e.chan_b));
						assert (got == expected_byte(exp_e.byte_addr))
						else flag_error($sformatf("byte at %h is %h, expected %h (chan_b=%b)",
							exp_e.byte_addr, got, expected_byte(exp_e.byte_addr),
							exp_e.chan_b));
					end
				end
			end
		end
	end

	// ================================================
	// Stimulus
	// ================================================

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (!nBNKB && n < 50)
		begin
			tick();
			n++;
		end
		if (!nBNKB)
		begin
			timeouts++;
			$display("Timeout: reset was never released");
		end
		tick();
	endtask

	// Writes words one by one and holds off while ioctl_wait is high
	task automatic download_block(input logic [7:0] index,
		input logic [SAMPLE_ADDR_W-1:0] start, input int words);
		logic                   in_range;
		logic [15:0]            data;
		logic [15:0]            got;
		logic [WORD_ADDR_W-1:0] waddr;
		int                     base_count;
		int                     i;
		int                     n;
		in_range       = (index >= 8'd16) && (index < 8'd64);
		base_count     = wr_count;
		ioctl.download = 1'b1;
		ioctl.index    = index;
		ioctl.wr       = 1'b0;
		tick();
		for (i = 0; i < words; i++)
		begin
			data       = 16'($urandom);
			ioctl.addr = start + 25'(2 * i);
			ioctl.data = data;
			ioctl.wr   = 1'b1;
			tick();
			ioctl.wr = 1'b0;
			assert (ioctl_wait == in_range)
			else flag_error($sformatf("ioctl_wait %b after write at index %0d",
				ioctl_wait, index));
			n = 0;
			while (ioctl_wait && n < 20)
			begin
				tick();
				n++;
			end
			if (ioctl_wait)
			begin
				timeouts++;
				$display("Timeout: ioctl_wait stuck high at index %0d", index);
			end
			if (in_range)
			begin
				waddr = load_word_addr(index, ioctl.addr);
				got   = wmem.exists(waddr) ? wmem[waddr] : ~data;
				assert (wr_count == base_count + i + 1 && got == data)
				else flag_error($sformatf("word %h holds %h, expected %h", waddr, got, data));
			end
		end
		// Give a stray write time to land
		if (!in_range)
		begin
			repeat (12) tick();
			assert (wr_count == base_count)
			else flag_error($sformatf("index %0d wrote to sample memory", index));
		end
		ioctl.download = 1'b0;
		tick();
	endtask

	// Drops the selected read enables and waits for all reads to finish
	task automatic fetch(input logic do_a, input logic do_b,
		input logic [SAMPLE_ADDR_W-1:0] ta, input logic [SAMPLE_ADDR_W-1:0] tb);
		int n;
		a_bank  = ta[23:20];
		a_addr  = ta[19:0];
		b_addr  = tb[23:0];
		use_pcm = ~tb[24];
		// B is served first
		if (do_b)
			exp_q.push_back(fetch_exp_t'{chan_b: 1'b1, byte_addr: tb});
		if (do_a)
			exp_q.push_back(fetch_exp_t'{chan_b: 1'b0, byte_addr: {1'b0, ta[23:0]}});
		a_roe_n = ~do_a;
		b_roe_n = ~do_b;
		tick();
		tick();
		a_roe_n = 1'b1;
		b_roe_n = 1'b1;
		n = 0;
		while (exp_q.size() > 0 && n < 100)
		begin
			tick();
			n++;
		end
		if (exp_q.size() > 0)
		begin
			timeouts++;
			$display("Timeout: %0d fetches never completed", exp_q.size());
			exp_q.delete();
		end
	endtask

	initial
	begin : main
		int k;
		int kind;
		ioctl   = '0;
		a_roe_n = 1'b1;
		b_roe_n = 1'b1;
		a_addr  = '0;
		a_bank  = '0;
		b_addr  = '0;
		use_pcm = 1'b0;
		void'($urandom(32'h25674a27));
		wait_reset_release();

		assert (!ioctl_wait && !mem_rd.req && !mem_wr.req)
		else flag_error($sformatf("after reset wait=%b rd.req=%b wr.req=%b",
			ioctl_wait, mem_rd.req, mem_wr.req));

		// Sample slots followed by two indices outside the range
		download_block(8'd16, 25'h0000000, 16);
		download_block(8'd17, 25'h0000000, 16);
		download_block(8'd40, 25'h0000100, 16);
		download_block(8'd48, 25'h0000000, 16);
		download_block(8'd8, 25'h0000040, 4);
		download_block(8'd64, 25'h0000040, 4);

		// Channel A with odd and even bytes and an unwritten word
		fetch(1'b1, 1'b0, 25'h0000003, '0);
		fetch(1'b1, 1'b0, 25'h0080004, '0);
		fetch(1'b1, 1'b0, 25'h0a12345, '0);
		// Channel B with use_pcm high then low
		fetch(1'b0, 1'b1, '0, 25'h0000006);
		fetch(1'b0, 1'b1, '0, 25'h1000009);
		// Both channels fall in the same cycle
		fetch(1'b1, 1'b1, 25'h000000a, 25'h100000b);

		// Random mix of A, B and both
		for (k = 0; k < 40; k++)
		begin
			kind = int'($urandom % 3);
			fetch(kind != 1, kind != 0, pick_target(), pick_target());
		end

		assert (exp_q.size() == 0 && ack_q.size() == 0)
		else flag_error("reads left unmatched at the end of the run");

		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
// ================================================
// Testbench clock and reset
// 4 ns clock, reset held low for 10 cycles
// ================================================
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
(
	output logic clk_sys,
	output logic nBNKB
);

	// Half period of 2 ns
	initial
	begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Release just after the tenth rising edge
	initial
	begin
		nBNKB = 1'b0;
		repeat (10) @(posedge clk_sys);
		#1;
		nBNKB = 1'b1;
	end

endmodule

`default_nettype wire
